// File: stk_pkg.sv
// Stack-cache invalidate package
// Shared sizes, ids and FSM encoding

package stk_pkg;

  // Number of engines sharing the invalidate pipe
  localparam int ENG_N = 4;

  // Width of an engine id
  localparam int ENGID_W = 2;

  // Lines held by each engine's stack cache
  localparam int LINE_N = 4;

  // Width of a line index within one engine
  localparam int LINE_W = 2;

  // Depth of the pending command queue in the sequencer
  localparam int QUEUE_N = 2;

  // Width of the one-hot sequencer state
  localparam int STATE_W = 3;

  // Engine id as carried on every port of the pipe
  typedef logic [ENGID_W-1:0] engid_t;

  // Line index inside one engine's stack cache
  typedef logic [LINE_W-1:0] line_t;

  // Sequencer states, one-hot encoded
  // IDLE waits for a queued command
  // ISSUE walks the lines of the popped engine
  // DRAIN waits for the writeback that frees the next slot
  typedef enum logic [STATE_W-1:0] {
    IDLE  = 3'b001,
    ISSUE = 3'b010,
    DRAIN = 3'b100
  } inv_state_t;

endpackage : stk_pkg

// File: queue_rf.sv
// Register-file FIFO
// Registered full and empty flags

`timescale 1ns/1ps

module queue_rf #(
  parameter int N = 2
, parameter int W = 2
) (
  input wire logic          i_push
, input wire logic [W-1:0]  i_push_dat
, input wire logic          i_pop
, output wire logic [W-1:0] o_pop_dat
, output wire logic         o_full_r
, output wire logic         o_empty_r
, input wire logic          clk
, input wire logic          i_rst_n
);

  // A depth of one still needs a one-bit pointer
  localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

  logic [W-1:0]     mem_r [N];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [PTR_W-1:0] wr_ptr_nxt;
  logic [PTR_W-1:0] rd_ptr_nxt;
  logic             full_r;
  logic             empty_r;
  logic             full_nxt;
  logic             empty_nxt;
  logic             push_ok;
  logic             pop_ok;

  // Pointers wrap at N so any depth works, not only powers of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(N - 1)) ? '0 : p + 1'b1;
  endfunction

  // A push while full and a pop while empty are both dropped
  assign push_ok = i_push & ~full_r;
  assign pop_ok  = i_pop & ~empty_r;

  assign wr_ptr_nxt = push_ok ? ptr_inc(wr_ptr_r) : wr_ptr_r;
  assign rd_ptr_nxt = pop_ok ? ptr_inc(rd_ptr_r) : rd_ptr_r;

  // Flags only move when exactly one side is active
  always_comb begin
    full_nxt  = full_r;
    empty_nxt = empty_r;
    if (push_ok && !pop_ok) begin
      full_nxt  = (wr_ptr_nxt == rd_ptr_nxt);
      empty_nxt = 1'b0;
    end else if (pop_ok && !push_ok) begin
      empty_nxt = (rd_ptr_nxt == wr_ptr_nxt);
      full_nxt  = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end else begin
      wr_ptr_r <= wr_ptr_nxt;
      rd_ptr_r <= rd_ptr_nxt;
      full_r   <= full_nxt;
      empty_r  <= empty_nxt;
    end
  end

  // Storage is written only on an accepted push
  always_ff @(posedge clk) begin
    if (push_ok) begin
      mem_r[wr_ptr_r] <= i_push_dat;
    end
  end

  // Head entry is visible whenever the queue is not empty
  assign o_pop_dat = mem_r[rd_ptr_r];
  assign o_full_r  = full_r;
  assign o_empty_r = empty_r;

endmodule : queue_rf

// File: stk_pipe_ad_inv.sv
// Stack-cache invalidate sequencer

`timescale 1ns/1ps

module stk_pipe_ad_inv (
  // Command enqueue
  input wire logic              i_push
, input wire stk_pkg::engid_t   i_push_dat
, output wire logic             o_full_r
  // Per-line issue to the execute pipe
, input wire logic              i_iss_ack
, output wire logic             o_iss_req
, output wire stk_pkg::engid_t  o_iss_engid
, output wire stk_pkg::line_t   o_iss_line
, output wire logic             o_iss_islast
  // Writeback feedback from the execute pipe
, input wire logic              i_wrbk_vld_r
, input wire stk_pkg::engid_t   i_wrbk_engid_r
, input wire logic              i_wrbk_nxtlast_r
, input wire logic              i_wrbk_islast_r
  // Clock and reset
, input wire logic              clk
, input wire logic              i_rst_n
);

  stk_pkg::inv_state_t state_r;
  stk_pkg::inv_state_t state_nxt;
  stk_pkg::engid_t     engid_r;
  stk_pkg::line_t      line_r;
  stk_pkg::engid_t     pop_dat;
  logic                empty_r;
  logic                pop;
  logic                iss_acc;
  logic                is_last;
  logic                drain_done;

  // Pending invalidate commands, one engine id per entry
  queue_rf #(.N(stk_pkg::QUEUE_N), .W(stk_pkg::ENGID_W)) u_cmd_q (
    .i_push     (i_push)
  , .i_push_dat (i_push_dat)
  , .i_pop      (pop)
  , .o_pop_dat  (pop_dat)
  , .o_full_r   (o_full_r)
  , .o_empty_r  (empty_r)
  , .clk        (clk)
  , .i_rst_n    (i_rst_n)
  );

  // A command leaves the queue only from IDLE
  assign pop = (state_r == stk_pkg::IDLE) & ~empty_r;

  // Transfer to the execute pipe on req and ack together
  assign iss_acc = o_iss_req & i_iss_ack;

  assign is_last = (line_r == stk_pkg::line_t'(stk_pkg::LINE_N - 1));

  // The nxtlast writeback of our own engine frees the sequencer, so the
  // next command can start while the final line is still in the pipe
  // An islast writeback releases it too, which only matters when the
  // cache is too small to have a nxtlast line
  assign drain_done = i_wrbk_vld_r
                    & (i_wrbk_nxtlast_r | i_wrbk_islast_r)
                    & (i_wrbk_engid_r == engid_r);

  always_comb begin
    state_nxt = state_r;
    unique case (state_r)
      stk_pkg::IDLE: begin
        if (!empty_r) begin
          state_nxt = stk_pkg::ISSUE;
        end
      end
      stk_pkg::ISSUE: begin
        // Stay here until the last line has been taken
        if (iss_acc && is_last) begin
          state_nxt = stk_pkg::DRAIN;
        end
      end
      stk_pkg::DRAIN: begin
        if (drain_done) begin
          state_nxt = stk_pkg::IDLE;
        end
      end
      default: begin
        state_nxt = stk_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_r <= stk_pkg::IDLE;
      line_r  <= '0;
    end else begin
      state_r <= state_nxt;
      // Line walk restarts at zero for every popped command
      if (pop) begin
        line_r <= '0;
      end else if (iss_acc) begin
        line_r <= line_r + stk_pkg::line_t'(1);
      end
    end
  end

  // Engine of the command being walked
  always_ff @(posedge clk) begin
    if (pop) begin
      engid_r <= pop_dat;
    end
  end

  // Request fields only change on ack, so they hold steady while waiting
  assign o_iss_req    = (state_r == stk_pkg::ISSUE);
  assign o_iss_engid  = engid_r;
  assign o_iss_line   = line_r;
  assign o_iss_islast = is_last;

endmodule : stk_pipe_ad_inv

// File: stk_line_tbl.sv
// Per-engine stack-cache line table

`timescale 1ns/1ps

module stk_line_tbl (
  // Allocation from outside the pipe
  input wire logic              i_alloc_vld
, input wire stk_pkg::engid_t   i_alloc_engid
, input wire stk_pkg::line_t    i_alloc_line
, input wire logic              i_alloc_dirty
  // Combinational lookup from the execute pipe
, input wire stk_pkg::engid_t   i_rd_engid
, input wire stk_pkg::line_t    i_rd_line
, output wire logic             o_rd_valid
, output wire logic             o_rd_dirty
  // Invalidate write from the execute pipe
, input wire logic              i_clr_vld
, input wire stk_pkg::engid_t   i_clr_engid
, input wire stk_pkg::line_t    i_clr_line
  // Clock and reset
, input wire logic              clk
, input wire logic              i_rst_n
);

  // One valid and one dirty bit per line of every engine
  logic [stk_pkg::ENG_N-1:0][stk_pkg::LINE_N-1:0] valid_r;
  logic [stk_pkg::ENG_N-1:0][stk_pkg::LINE_N-1:0] dirty_r;
  logic [stk_pkg::ENG_N-1:0][stk_pkg::LINE_N-1:0] valid_nxt;
  logic [stk_pkg::ENG_N-1:0][stk_pkg::LINE_N-1:0] dirty_nxt;

  always_comb begin
    valid_nxt = valid_r;
    dirty_nxt = dirty_r;

    // Allocation marks the line present and may mark it dirty
    // A clean allocation leaves an existing dirty bit alone
    if (i_alloc_vld) begin
      valid_nxt[i_alloc_engid][i_alloc_line] = 1'b1;
      if (i_alloc_dirty) begin
        dirty_nxt[i_alloc_engid][i_alloc_line] = 1'b1;
      end
    end

    // Clear comes last so it beats an allocation of the same line
    if (i_clr_vld) begin
      valid_nxt[i_clr_engid][i_clr_line] = 1'b0;
      dirty_nxt[i_clr_engid][i_clr_line] = 1'b0;
    end
  end

  // The whole table starts empty
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      valid_r <= '0;
      dirty_r <= '0;
    end else begin
      valid_r <= valid_nxt;
      dirty_r <= dirty_nxt;
    end
  end

  // Lookup sees registered state only, with no bypass of same-cycle writes
  assign o_rd_valid = valid_r[i_rd_engid][i_rd_line];
  assign o_rd_dirty = dirty_r[i_rd_engid][i_rd_line];

endmodule : stk_line_tbl

// File: stk_pipe_exe.sv
// Invalidate execute pipe
// Lookup, clear, writeback and eviction

`timescale 1ns/1ps

module stk_pipe_exe (
  // Issue from the sequencer
  input wire logic              i_iss_req
, input wire stk_pkg::engid_t   i_iss_engid
, input wire stk_pkg::line_t    i_iss_line
, input wire logic              i_iss_islast
, output wire logic             o_iss_ack
  // Table lookup
, output wire stk_pkg::engid_t  o_rd_engid
, output wire stk_pkg::line_t   o_rd_line
, input wire logic              i_rd_valid
, input wire logic              i_rd_dirty
  // Table clear
, output wire logic             o_clr_vld
, output wire stk_pkg::engid_t  o_clr_engid
, output wire stk_pkg::line_t   o_clr_line
  // Writeback to the sequencer
, output wire logic             o_wrbk_vld_r
, output wire stk_pkg::engid_t  o_wrbk_engid_r
, output wire logic             o_wrbk_nxtlast_r
, output wire logic             o_wrbk_islast_r
  // Eviction of dirty lines
, output wire logic             o_evict_vld
, output wire stk_pkg::engid_t  o_evict_engid
, output wire stk_pkg::line_t   o_evict_line
, input wire logic              i_evict_rdy
  // Command completion
, output wire logic             o_done_vld
, output wire stk_pkg::engid_t  o_done_engid
  // Clock and reset
, input wire logic              clk
, input wire logic              i_rst_n
);

  logic            s1_vld_r;
  stk_pkg::engid_t s1_engid_r;
  stk_pkg::line_t  s1_line_r;
  logic            s1_islast_r;
  logic            wrbk_vld_r;
  stk_pkg::engid_t wrbk_engid_r;
  logic            wrbk_nxtlast_r;
  logic            wrbk_islast_r;
  logic            evict_vld_r;
  stk_pkg::engid_t evict_engid_r;
  stk_pkg::line_t  evict_line_r;
  logic            done_pend_r;
  stk_pkg::engid_t done_engid_r;
  logic            stall;
  logic            adv;
  logic            iss_acc;
  logic            evict_ld;

  // Freeze the pipe while an eviction waits on the consumer
  // A pending done also holds it, so no eviction of the next command
  // can slip ahead of this command's completion
  assign stall    = evict_vld_r & (~i_evict_rdy | done_pend_r);
  assign adv      = s1_vld_r & ~stall;
  assign iss_acc  = i_iss_req & ~stall;
  assign evict_ld = adv & i_rd_valid & i_rd_dirty;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      s1_vld_r    <= 1'b0;
      wrbk_vld_r  <= 1'b0;
      evict_vld_r <= 1'b0;
      done_pend_r <= 1'b0;
    end else begin
      if (!stall) begin
        s1_vld_r <= i_iss_req;
      end
      // Writeback pulses once per op as it leaves stage one
      wrbk_vld_r  <= adv;
      evict_vld_r <= evict_ld | (evict_vld_r & ~i_evict_rdy);
      if (adv && s1_islast_r) begin
        done_pend_r <= 1'b1;
      end else if (o_done_vld) begin
        done_pend_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (iss_acc) begin
      s1_engid_r  <= i_iss_engid;
      s1_line_r   <= i_iss_line;
      s1_islast_r <= i_iss_islast;
    end
    if (adv) begin
      wrbk_engid_r   <= s1_engid_r;
      wrbk_nxtlast_r <= (s1_line_r == stk_pkg::line_t'(stk_pkg::LINE_N - 2));
      wrbk_islast_r  <= s1_islast_r;
    end
    if (evict_ld) begin
      evict_engid_r <= s1_engid_r;
      evict_line_r  <= s1_line_r;
    end
    if (adv && s1_islast_r) begin
      done_engid_r <= s1_engid_r;
    end
  end

  assign o_iss_ack = ~stall;

  // Stage one reads the table and clears the line as it advances
  assign o_rd_engid  = s1_engid_r;
  assign o_rd_line   = s1_line_r;
  assign o_clr_vld   = adv;
  assign o_clr_engid = s1_engid_r;
  assign o_clr_line  = s1_line_r;

  assign o_wrbk_vld_r     = wrbk_vld_r;
  assign o_wrbk_engid_r   = wrbk_engid_r;
  assign o_wrbk_nxtlast_r = wrbk_nxtlast_r;
  assign o_wrbk_islast_r  = wrbk_islast_r;

  assign o_evict_vld   = evict_vld_r;
  assign o_evict_engid = evict_engid_r;
  assign o_evict_line  = evict_line_r;

  // Done waits until the command's last eviction has been taken
  assign o_done_vld   = done_pend_r & ~evict_vld_r;
  assign o_done_engid = done_engid_r;

endmodule : stk_pipe_exe

// File: stk_inv_top.sv
// Stack-cache invalidate top level

`timescale 1ns/1ps

module stk_inv_top (
  input wire logic              clk
, input wire logic              i_rst_n
  // Command enqueue
, input wire logic              i_push
, input wire stk_pkg::engid_t   i_push_dat
, output wire logic             o_full_r
  // Line allocation
, input wire logic              i_alloc_vld
, input wire stk_pkg::engid_t   i_alloc_engid
, input wire stk_pkg::line_t    i_alloc_line
, input wire logic              i_alloc_dirty
  // Eviction output
, output wire logic             o_evict_vld
, output wire stk_pkg::engid_t  o_evict_engid
, output wire stk_pkg::line_t   o_evict_line
, input wire logic              i_evict_rdy
  // Completion
, output wire logic             o_done_vld
, output wire stk_pkg::engid_t  o_done_engid
);

  logic            iss_req;
  logic            iss_ack;
  stk_pkg::engid_t iss_engid;
  stk_pkg::line_t  iss_line;
  logic            iss_islast;
  logic            wrbk_vld_r;
  stk_pkg::engid_t wrbk_engid_r;
  logic            wrbk_nxtlast_r;
  logic            wrbk_islast_r;
  stk_pkg::engid_t rd_engid;
  stk_pkg::line_t  rd_line;
  logic            rd_valid;
  logic            rd_dirty;
  logic            clr_vld;
  stk_pkg::engid_t clr_engid;
  stk_pkg::line_t  clr_line;

  stk_pipe_ad_inv u_inv (
    .i_push (i_push), .i_push_dat (i_push_dat), .o_full_r (o_full_r)
  , .i_iss_ack (iss_ack), .o_iss_req (iss_req), .o_iss_engid (iss_engid)
  , .o_iss_line (iss_line), .o_iss_islast (iss_islast)
  , .i_wrbk_vld_r (wrbk_vld_r), .i_wrbk_engid_r (wrbk_engid_r)
  , .i_wrbk_nxtlast_r (wrbk_nxtlast_r), .i_wrbk_islast_r (wrbk_islast_r)
  , .clk (clk), .i_rst_n (i_rst_n)
  );

  stk_line_tbl u_tbl (
    .i_alloc_vld (i_alloc_vld), .i_alloc_engid (i_alloc_engid)
  , .i_alloc_line (i_alloc_line), .i_alloc_dirty (i_alloc_dirty)
  , .i_rd_engid (rd_engid), .i_rd_line (rd_line)
  , .o_rd_valid (rd_valid), .o_rd_dirty (rd_dirty)
  , .i_clr_vld (clr_vld), .i_clr_engid (clr_engid), .i_clr_line (clr_line)
  , .clk (clk), .i_rst_n (i_rst_n)
  );

  stk_pipe_exe u_exe (
    .i_iss_req (iss_req), .i_iss_engid (iss_engid), .i_iss_line (iss_line)
  , .i_iss_islast (iss_islast), .o_iss_ack (iss_ack)
  , .o_rd_engid (rd_engid), .o_rd_line (rd_line)
  , .i_rd_valid (rd_valid), .i_rd_dirty (rd_dirty)
  , .o_clr_vld (clr_vld), .o_clr_engid (clr_engid), .o_clr_line (clr_line)
  , .o_wrbk_vld_r (wrbk_vld_r), .o_wrbk_engid_r (wrbk_engid_r)
  , .o_wrbk_nxtlast_r (wrbk_nxtlast_r), .o_wrbk_islast_r (wrbk_islast_r)
  , .o_evict_vld (o_evict_vld), .o_evict_engid (o_evict_engid)
  , .o_evict_line (o_evict_line), .i_evict_rdy (i_evict_rdy)
  , .o_done_vld (o_done_vld), .o_done_engid (o_done_engid)
  , .clk (clk), .i_rst_n (i_rst_n)
  );

endmodule : stk_inv_top

// File: stk_inv_props.sv
// Handshake and FSM assertions

`timescale 1ns/1ps

module stk_inv_props (
  input wire logic                clk
, input wire logic                i_rst_n
, input wire logic                push
, input wire logic                full
, input wire logic                req
, input wire logic                ack
, input wire logic [4:0]          req_dat
, input wire stk_pkg::inv_state_t state
, input wire logic                wrbk_vld
, input wire logic                wrbk_nxtlast
, input wire logic                evict_vld
, input wire logic                evict_rdy
, input wire logic [3:0]          evict_dat
);

  // The command queue never sees a push while it reports full
  a_no_push_full: assert property (@(posedge clk) disable iff (!i_rst_n)
    !(push && full))
    else $error("push accepted while the command queue was full");

  // An issue request holds its fields until it is acknowledged
  a_req_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    (req && !ack) |=> (req && $stable(req_dat)))
    else $error("issue request changed before ack");

  // The nxtlast writeback trails the islast ack by one cycle
  // So it only ever reaches the sequencer while it drains
  a_nxtlast_drain: assert property (@(posedge clk) disable iff (!i_rst_n)
    (wrbk_vld && wrbk_nxtlast) |-> (state == stk_pkg::DRAIN))
    else $error("nxtlast writeback arrived outside the drain state");

  // A blocked eviction waits with unchanged fields
  a_evict_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
    (evict_vld && !evict_rdy) |=> (evict_vld && $stable(evict_dat)))
    else $error("eviction changed or dropped while blocked");

endmodule : stk_inv_props

// Sequencer side covers the queue, the request and the FSM
bind stk_pipe_ad_inv stk_inv_props u_props_inv (
  .clk (clk), .i_rst_n (i_rst_n), .push (i_push), .full (o_full_r)
, .req (o_iss_req), .ack (i_iss_ack)
, .req_dat ({o_iss_engid, o_iss_line, o_iss_islast}), .state (state_r)
, .wrbk_vld (i_wrbk_vld_r), .wrbk_nxtlast (i_wrbk_nxtlast_r)
, .evict_vld (1'b0), .evict_rdy (1'b1), .evict_dat (4'h0)
);

// Execute side covers the request as seen there and the eviction output
bind stk_pipe_exe stk_inv_props u_props_exe (
  .clk (clk), .i_rst_n (i_rst_n), .push (1'b0), .full (1'b0)
, .req (i_iss_req), .ack (o_iss_ack)
, .req_dat ({i_iss_engid, i_iss_line, i_iss_islast}), .state (stk_pkg::IDLE)
, .wrbk_vld (1'b0), .wrbk_nxtlast (1'b0)
, .evict_vld (o_evict_vld), .evict_rdy (i_evict_rdy)
, .evict_dat ({o_evict_engid, o_evict_line})
);

// File: stk_inv_checker.sv
// Invalidate pipe checker with table model

`timescale 1ns/1ps

module stk_inv_checker (
  input wire logic            clk
, input wire logic            i_rst_n
, input wire logic            i_push
, input wire stk_pkg::engid_t i_push_dat
, input wire logic            o_full_r
, input wire logic            i_alloc_vld
, input wire stk_pkg::engid_t i_alloc_engid
, input wire stk_pkg::line_t  i_alloc_line
, input wire logic            i_alloc_dirty
, input wire logic            o_evict_vld
, input wire stk_pkg::engid_t o_evict_engid
, input wire stk_pkg::line_t  o_evict_line
, input wire logic            i_evict_rdy
, input wire logic            o_done_vld
, input wire stk_pkg::engid_t o_done_engid
);

  int err_cnt = 0;
  int push_cnt = 0;
  int done_cnt = 0;
  int evict_cnt = 0;

  // Model of the line table, one bit per line
  logic [stk_pkg::LINE_N-1:0] valid_m [stk_pkg::ENG_N];
  logic [stk_pkg::LINE_N-1:0] dirty_m [stk_pkg::ENG_N];

  // Outstanding commands with the lines each one still has to evict
  stk_pkg::engid_t            exp_eng [$];
  logic [stk_pkg::LINE_N-1:0] exp_mask [$];

  // Eviction seen blocked on the previous edge
  logic            wait_r = 1'b0;
  stk_pkg::engid_t wait_eng;
  stk_pkg::line_t  wait_line;

  // Lines must leave in ascending order, so the next one is the lowest set bit
  function automatic int lowest_line(input logic [stk_pkg::LINE_N-1:0] m);
    for (int i = 0; i < stk_pkg::LINE_N; i++) begin
      if (m[i]) begin
        return i;
      end
    end
    return -1;
  endfunction

  always @(posedge clk) begin
    logic [stk_pkg::LINE_N-1:0] tmp;
    int exp_line;
    if (!i_rst_n) begin
      for (int e = 0; e < stk_pkg::ENG_N; e++) begin
        valid_m[e] = '0;
        dirty_m[e] = '0;
      end
      exp_eng.delete();
      exp_mask.delete();
      wait_r = 1'b0;
    end else begin
      // A waiting eviction must still be there with the same fields
      if (wait_r) begin
        if (!o_evict_vld) begin
          $display("Eviction vanished at %0t while the consumer was not ready", $time);
          err_cnt++;
        end else if (o_evict_engid != wait_eng || o_evict_line != wait_line) begin
          $display("[FAIL] t=%0t o_evict_line exp=%0d.%0d got=%0d.%0d", $time,
                   wait_eng, wait_line, o_evict_engid, o_evict_line);
          err_cnt++;
        end
      end
      wait_r    = o_evict_vld & ~i_evict_rdy;
      wait_eng  = o_evict_engid;
      wait_line = o_evict_line;

      // Each taken eviction belongs to the oldest outstanding command
      if (o_evict_vld && i_evict_rdy) begin
        evict_cnt++;
        if (exp_eng.size() == 0) begin
          $display("Eviction at %0t with no command outstanding", $time);
          err_cnt++;
        end else begin
          exp_line = lowest_line(exp_mask[0]);
          if (o_evict_engid != exp_eng[0]) begin
            $display("[FAIL] t=%0t o_evict_engid exp=%0d got=%0d", $time,
                     exp_eng[0], o_evict_engid);
            err_cnt++;
          end else if (exp_line < 0) begin
            $display("Unexpected eviction of line %0d at %0t, none was dirty",
                     o_evict_line, $time);
            err_cnt++;
          end else if (int'(o_evict_line) != exp_line) begin
            $display("[FAIL] t=%0t o_evict_line exp=%0d got=%0d", $time,
                     exp_line, o_evict_line);
            err_cnt++;
          end else begin
            tmp = exp_mask[0];
            tmp[o_evict_line] = 1'b0;
            exp_mask[0] = tmp;
          end
        end
      end

      // Completion closes the oldest command in push order
      if (o_done_vld) begin
        done_cnt++;
        if (exp_eng.size() == 0) begin
          $display("Completion at %0t with no command outstanding", $time);
          err_cnt++;
        end else begin
          if (o_done_engid != exp_eng[0]) begin
            $display("[FAIL] t=%0t o_done_engid exp=%0d got=%0d", $time,
                     exp_eng[0], o_done_engid);
            err_cnt++;
          end
          if (exp_mask[0] != '0) begin
            $display("Completion at %0t came before all evictions, missing mask %b",
                     $time, exp_mask[0]);
            err_cnt++;
          end
          void'(exp_eng.pop_front());
          void'(exp_mask.pop_front());
        end
      end

      // The engine is untouched until its command ends, so its dirty
      // lines at push time are exactly what the command will evict
      if (i_push && !o_full_r) begin
        push_cnt++;
        exp_eng.push_back(i_push_dat);
        exp_mask.push_back(valid_m[i_push_dat] & dirty_m[i_push_dat]);
        valid_m[i_push_dat] = '0;
        dirty_m[i_push_dat] = '0;
      end

      // A clean allocation keeps an earlier dirty bit
      if (i_alloc_vld) begin
        valid_m[i_alloc_engid][i_alloc_line] = 1'b1;
        if (i_alloc_dirty) begin
          dirty_m[i_alloc_engid][i_alloc_line] = 1'b1;
        end
      end
    end
  end

endmodule : stk_inv_checker

// File: tb_stk_inv.sv
// Stack-cache invalidate testbench

`timescale 1ns/1ps

module tb_stk_inv;

  localparam int RAND_CYCLES = 2000;
  localparam int MAX_CMDS    = RAND_CYCLES / 2 + 16;
  localparam int STALL_F     = 8;
  localparam int WD_CYCLES   = MAX_CMDS * stk_pkg::LINE_N * STALL_F + 400;

  logic            clk = 1'b0;
  logic            i_rst_n;
  logic            i_push;
  stk_pkg::engid_t i_push_dat;
  logic            o_full_r;
  logic            i_alloc_vld;
  stk_pkg::engid_t i_alloc_engid;
  stk_pkg::line_t  i_alloc_line;
  logic            i_alloc_dirty;
  logic            o_evict_vld;
  stk_pkg::engid_t o_evict_engid;
  stk_pkg::line_t  o_evict_line;
  logic            i_evict_rdy;
  logic            o_done_vld;
  stk_pkg::engid_t o_done_engid;

  logic [31:0] rng = 32'h5230_81ea;
  int          tb_err = 0;
  int          busy [stk_pkg::ENG_N];

  always #20 clk = ~clk;

  stk_inv_top dut0 (.*);

  stk_inv_checker chk0 (.*);

  // Commands per engine that are queued or in flight
  // Completions are counted on the falling edge, between stimulus edges
  always @(negedge clk) begin
    if (i_rst_n && o_done_vld) begin
      busy[o_done_engid] = busy[o_done_engid] - 1;
    end
  end

  // Run limit scales with the worst number of commands and stalls
  initial begin
    #(WD_CYCLES * 40);
    $display("Watchdog expired after %0d cycles, the pipe stopped making progress",
             WD_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic int total_err();
    return tb_err + chk0.err_cnt;
  endfunction

  task automatic report(input string name, input int err_before);
    if (total_err() == err_before) begin
      $display("test %s: pass", name);
    end else begin
      $display("test %s: fail with %0d errors", name, total_err() - err_before);
    end
  endtask

  // Holds the push until the queue has room
  // Full is read a cycle after any push
  task automatic push_cmd(input stk_pkg::engid_t e);
    @(posedge clk);
    while (o_full_r) begin
      @(posedge clk);
    end
    i_push     <= 1'b1;
    i_push_dat <= e;
    busy[e] = busy[e] + 1;
    @(posedge clk);
    i_push <= 1'b0;
  endtask

  task automatic alloc_line(input stk_pkg::engid_t e, input stk_pkg::line_t l,
                            input logic d);
    @(posedge clk);
    i_alloc_vld   <= 1'b1;
    i_alloc_engid <= e;
    i_alloc_line  <= l;
    i_alloc_dirty <= d;
    @(posedge clk);
    i_alloc_vld <= 1'b0;
  endtask

  // Waits until every pushed command has completed
  task automatic wait_drain();
    int n;
    @(posedge clk);
    i_evict_rdy <= 1'b1;
    do begin
      @(posedge clk);
      n = 0;
      for (int e = 0; e < stk_pkg::ENG_N; e++) begin
        n += busy[e];
      end
    end while (n != 0);
    repeat (4) @(posedge clk);
  endtask

  task automatic run_random(input int n_cyc);
    logic [31:0]     r;
    logic            pushed_last;
    logic            pushing;
    stk_pkg::engid_t pe;
    stk_pkg::engid_t ae;
    pushed_last = 1'b0;
    for (int i = 0; i < n_cyc; i++) begin
      @(posedge clk);
      r = next_rand();
      i_evict_rdy <= (r[7:0] < 8'd180);
      pe = r[9:8];
      ae = r[17:16];
      // A gap after each push keeps the sampled full flag current
      pushing = !pushed_last && !o_full_r && (r[13:12] == 2'd0);
      i_push <= pushing;
      if (pushing) begin
        i_push_dat <= pe;
        busy[pe] = busy[pe] + 1;
      end
      pushed_last = pushing;
      // Allocations stay off engines with a command queued or running
      if (r[18] && busy[ae] == 0 && !(pushing && ae == pe)) begin
        i_alloc_vld   <= 1'b1;
        i_alloc_engid <= ae;
        i_alloc_line  <= r[21:20];
        i_alloc_dirty <= r[22];
      end else begin
        i_alloc_vld <= 1'b0;
      end
    end
    @(posedge clk);
    i_push      <= 1'b0;
    i_alloc_vld <= 1'b0;
  endtask

  initial begin
    int  err0;
    logic saw_full;
    i_rst_n       = 1'b0;
    i_push        = 1'b0;
    i_push_dat    = '0;
    i_alloc_vld   = 1'b0;
    i_alloc_engid = '0;
    i_alloc_line  = '0;
    i_alloc_dirty = 1'b0;
    i_evict_rdy   = 1'b1;
    for (int e = 0; e < stk_pkg::ENG_N; e++) begin
      busy[e] = 0;
    end
    repeat (4) @(posedge clk);
    i_rst_n <= 1'b1;

    err0 = total_err();
    @(posedge clk);
    if (o_full_r !== 1'b0) begin
      $display("[FAIL] t=%0t o_full_r exp=0 got=%b", $time, o_full_r);
      tb_err++;
    end
    if (o_evict_vld !== 1'b0) begin
      $display("[FAIL] t=%0t o_evict_vld exp=0 got=%b", $time, o_evict_vld);
      tb_err++;
    end
    if (o_done_vld !== 1'b0) begin
      $display("[FAIL] t=%0t o_done_vld exp=0 got=%b", $time, o_done_vld);
      tb_err++;
    end
    report("reset_state", err0);

    // Dirty lines with the consumer stalled keep engine 0 busy while the queue fills
    err0 = total_err();
    alloc_line(2'd0, 2'd0, 1'b1);
    alloc_line(2'd0, 2'd2, 1'b1);
    @(posedge clk);
    i_evict_rdy <= 1'b0;
    push_cmd(2'd0);
    push_cmd(2'd1);
    push_cmd(2'd2);
    saw_full = 1'b0;
    repeat (20) begin
      @(posedge clk);
      if (o_full_r) begin
        saw_full = 1'b1;
      end
    end
    if (!saw_full) begin
      $display("Queue full flag never rose with %0d commands waiting", stk_pkg::QUEUE_N);
      tb_err++;
    end
    wait_drain();
    report("queue_limit", err0);

    // A repeat command on a cleared engine must not evict again
    err0 = total_err();
    alloc_line(2'd3, 2'd1, 1'b1);
    alloc_line(2'd3, 2'd2, 1'b1);
    alloc_line(2'd3, 2'd3, 1'b0);
    push_cmd(2'd3);
    wait_drain();
    push_cmd(2'd3);
    wait_drain();
    report("clearing", err0);

    err0 = total_err();
    run_random(RAND_CYCLES);
    wait_drain();
    if (chk0.done_cnt != chk0.push_cnt) begin
      $display("Only %0d of %0d commands completed", chk0.done_cnt, chk0.push_cnt);
      tb_err++;
    end
    report("random_backpressure", err0);

    $display("commands %0d evictions %0d completions %0d errors %0d",
             chk0.push_cnt, chk0.evict_cnt, chk0.done_cnt, total_err());
    if (total_err() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_stk_inv

// File: stk_inv.f
stk_pkg.sv
queue_rf.sv
stk_pipe_ad_inv.sv
stk_line_tbl.sv
stk_pipe_exe.sv
stk_inv_top.sv
stk_inv_props.sv
stk_inv_checker.sv
tb_stk_inv.sv

// File: Makefile
# Verilator flow for the stack-cache invalidate pipe

VERILATOR ?= verilator
TOP       ?= tb_stk_inv
RTL_TOP   ?= stk_inv_top
FLIST     ?= stk_inv.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
	  echo "simulation reported failures"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
	  echo "simulation ended without a pass line"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
